//--- verilog/loader_consts.svh
`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// Serial bit time in clock cycles.
`define CLKS_PER_BIT 8

// The word memory is split into NUM_BANKS banks of BANK_DEPTH words each.
`define NUM_BANKS 4
`define BANK_DEPTH 16

`endif

//--- verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

    typedef logic [7:0] byte_t;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

endpackage

`default_nettype wire

//--- verilog/mem_pkg.sv
`default_nettype none

`include "loader_consts.svh"

package mem_pkg;

    localparam int WORD_W = 32;
    localparam int BANK_SEL_W = $clog2(`NUM_BANKS);
    localparam int BANK_ADDR_W = $clog2(`BANK_DEPTH);
    localparam int WORD_ADDR_W = BANK_ADDR_W + BANK_SEL_W;  // Bank in the low bits.

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [BANK_SEL_W-1:0] bank_sel_t;
    typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

endpackage

`default_nettype wire

//--- verilog/uart_rx.sv
`default_nettype none

`include "loader_consts.svh"

module uart_rx import uart_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  rx,
    output byte_t rx_byte,
    output logic  byte_valid,
    output logic  frame_error
);

    localparam int CNT_W = $clog2(`CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`CLKS_PER_BIT - 1);

    rx_state_t        state;
    logic [1:0]       rx_sync;
    logic             rx_s;
    logic             rx_prev;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic             sample_tick;

    assign rx_s = rx_sync[1];
    assign sample_tick = (bit_cnt == FULL_BIT);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_sync <= 2'b11;  // Idle line is high.
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= IDLE;
            bit_cnt     <= '0;
            bit_idx     <= '0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
            bit_cnt     <= bit_cnt + 1'b1;
            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    if (rx_prev && !rx_s) begin
                        state <= START;
                    end
                end
                START: begin
                    if (bit_cnt == HALF_BIT) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? IDLE : DATA;  // A high line here was a glitch.
                    end
                end
                DATA: begin
                    if (sample_tick) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (sample_tick) begin
                        state       <= IDLE;
                        byte_valid  <= rx_s;
                        frame_error <= !rx_s;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top.
    always_ff @(posedge clk) begin
        if (state == DATA && sample_tick) begin
            rx_byte <= {rx_s, rx_byte[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- verilog/word_assembler.sv
`default_nettype none

`include "loader_consts.svh"

module word_assembler import uart_pkg::*, mem_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    input  byte_t                 rx_byte,
    input  logic                  byte_valid,
    output word_t                 wr_data,
    output bank_addr_t            wr_row,
    output logic [`NUM_BANKS-1:0] bank_wr_en,
    output logic                  word_written,
    output word_addr_t            word_count
);

    word_t      shift_reg;
    logic [1:0] byte_cnt;
    logic       word_done;
    bank_sel_t  next_sel;
    bank_addr_t next_row;

    assign word_done = byte_valid && (byte_cnt == 2'd3);
    assign {next_row, next_sel} = word_count;
    assign wr_data = shift_reg;  // Complete while word_written is high.

    // First byte ends up in the most significant position.
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            shift_reg <= {shift_reg[WORD_W-9:0], rx_byte};
        end
    end

    always_ff @(posedge clk) begin
        if (word_done) begin
            wr_row <= next_row;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_cnt     <= '0;
            bank_wr_en   <= '0;
            word_written <= 1'b0;
            word_count   <= '0;
        end else begin
            word_written <= word_done;
            bank_wr_en   <= '0;
            if (byte_valid) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            if (word_done) begin
                bank_wr_en <= `NUM_BANKS'(1) << next_sel;
                word_count <= word_count + 1'b1;  // Wraps at full capacity.
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/bank_ram.sv
`default_nettype none

`include "loader_consts.svh"

module bank_ram import mem_pkg::*; (
    input  logic       clk,
    input  logic       wr_en,
    input  bank_addr_t wr_row,
    input  word_t      wr_data,
    input  bank_addr_t rd_row,
    output word_t      rd_data
);

    word_t mem [`BANK_DEPTH];

    // Read every cycle; a same-row write shows up on the next read.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_row] <= wr_data;
        end
        rd_data <= mem[rd_row];
    end

endmodule

`default_nettype wire

//--- verilog/bank_read_mux.sv
`default_nettype none

`include "loader_consts.svh"

module bank_read_mux import mem_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       rd_en,
    input  word_addr_t rd_addr,
    output bank_addr_t rd_row,
    input  word_t      bank_rd_data [`NUM_BANKS],
    output word_t      rd_data,
    output logic       rd_valid
);

    bank_sel_t rd_sel;
    bank_sel_t sel_q;

    assign {rd_row, rd_sel} = rd_addr;

    // Bank select follows the RAM read latency.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            sel_q <= rd_sel;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    assign rd_data = bank_rd_data[sel_q];

endmodule

`default_nettype wire

//--- verilog/loader_top.sv
`default_nettype none

`include "loader_consts.svh"

module loader_top import uart_pkg::*, mem_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       rx,
    input  logic       rd_en,
    input  word_addr_t rd_addr,
    output word_t      rd_data,
    output logic       rd_valid,
    output logic       word_written,
    output word_addr_t word_count,
    output logic       frame_error
);

    byte_t                 rx_byte;
    logic                  byte_valid;
    word_t                 wr_data;
    bank_addr_t            wr_row;
    logic [`NUM_BANKS-1:0] bank_wr_en;
    bank_addr_t            rd_row;
    word_t                 bank_rd_data [`NUM_BANKS];

    uart_rx u_uart_rx (
        .clk         (clk),
        .reset_n     (reset_n),
        .rx          (rx),
        .rx_byte     (rx_byte),
        .byte_valid  (byte_valid),
        .frame_error (frame_error)
    );

    word_assembler u_word_assembler (
        .clk          (clk),
        .reset_n      (reset_n),
        .rx_byte      (rx_byte),
        .byte_valid   (byte_valid),
        .wr_data      (wr_data),
        .wr_row       (wr_row),
        .bank_wr_en   (bank_wr_en),
        .word_written (word_written),
        .word_count   (word_count)
    );

    for (genvar gi = 0; gi < `NUM_BANKS; gi++) begin : g_bank
        bank_ram u_bank_ram (
            .clk     (clk),
            .wr_en   (bank_wr_en[gi]),
            .wr_row  (wr_row),
            .wr_data (wr_data),
            .rd_row  (rd_row),
            .rd_data (bank_rd_data[gi])
        );
    end

    bank_read_mux u_bank_read_mux (
        .clk          (clk),
        .reset_n      (reset_n),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_row       (rd_row),
        .bank_rd_data (bank_rd_data),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid)
    );

endmodule

`default_nettype wire

//--- tb/loader_tb.sv
`default_nettype none

`include "loader_consts.svh"

module loader_tb import uart_pkg::*, mem_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int MEM_WORDS = `NUM_BANKS * `BANK_DEPTH;
    localparam int RAND_WORDS = 20;
    localparam int TOTAL_BYTES = 4 * (MEM_WORDS + 1) + 1;  // Full memory, the wrap word, one bad byte.
    localparam int WATCHDOG_TIME = TOTAL_BYTES * 10 * `CLKS_PER_BIT * CLK_PERIOD + 2000;
    localparam int WORD_WAIT = 2 * `CLKS_PER_BIT;

    logic       clk = 1'b0;
    logic       reset_n;
    logic       rx;
    logic       rd_en;
    word_addr_t rd_addr;
    word_t      rd_data;
    logic       rd_valid;
    logic       word_written;
    word_addr_t word_count;
    logic       frame_error;

    word_t exp_mem [int];  // Expected memory, keyed by word address.
    int    exp_count = 0;
    int    exp_written = 0;
    int    n_written = 0;
    int    n_frame_err = 0;
    int    errors = 0;
    int    err_mark = 0;
    int    n_pass = 0;
    int    n_fail = 0;
    int    seed = 32'hb692_9db8;
    string test_name = "reset";

    loader_top dut0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .rx           (rx),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .word_written (word_written),
        .word_count   (word_count),
        .frame_error  (frame_error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (reset_n && word_written) n_written <= n_written + 1;
        if (reset_n && frame_error) n_frame_err <= n_frame_err + 1;
    end

    a_rd_valid: assert property (@(posedge clk) disable iff (!reset_n) rd_valid == $past(rd_en))
        else begin
            $display("Error in %s: rd_valid did not follow rd_en by one cycle", test_name);
            errors++;
        end

    a_reset_quiet: assert property (@(posedge clk) !reset_n |-> !word_written && !frame_error)
        else begin
            $display("Error: word_written or frame_error was high during reset");
            errors++;
        end

    a_one_hot: assert property (@(posedge clk) disable iff (!reset_n)
            word_written ? $onehot(dut0.bank_wr_en) : (dut0.bank_wr_en == '0))
        else begin
            $display("Error in %s: bank write enables were not one-hot", test_name);
            errors++;
        end

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s: expected %h, actual %h", test_name, expected, actual);
            errors++;
        end
    endtask

    task automatic drive_bit(input logic value);
        rx = value;
        repeat (`CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic send_byte(input byte_t data, input logic stop_bit);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);  // LSB first.
        end
        drive_bit(stop_bit);
    endtask

    // The line must go high again before the next start bit can be seen.
    task automatic send_bad_byte(input byte_t data);
        send_byte(data, 1'b0);
        drive_bit(1'b1);
    endtask

    task automatic send_glitch();
        rx = 1'b0;
        repeat (`CLKS_PER_BIT / 2 - 2) @(negedge clk);
        drive_bit(1'b1);
    endtask

    // Records the word in the model and waits for the write strobe.
    task automatic finish_word(input word_t w);
        int waited;
        waited = 0;
        exp_mem[exp_count] = w;
        exp_count = (exp_count + 1) % MEM_WORDS;
        exp_written++;
        while (n_written < exp_written && waited < WORD_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (n_written == exp_written) else begin
            $display("Error in %s: word_written pulsed %0d times, not %0d times",
                     test_name, n_written, exp_written);
            errors++;
        end
    endtask

    task automatic send_word(input word_t w);
        send_byte(w[31:24], 1'b1);
        send_byte(w[23:16], 1'b1);
        send_byte(w[15:8], 1'b1);
        send_byte(w[7:0], 1'b1);
        finish_word(w);
    endtask

    // Issues count reads back to back and checks each result one cycle later.
    task automatic read_burst(input int first, input int count);
        word_t pending[$];
        word_t exp_w;
        for (int i = 0; i <= count; i++) begin
            if (i > 0) begin
                exp_w = pending.pop_front();
                check_value(32'd1, 32'(rd_valid));
                check_value(exp_w, rd_data);
            end
            if (i < count) begin
                rd_en = 1'b1;
                rd_addr = word_addr_t'(first + i);
                pending.push_back(exp_mem[(first + i) % MEM_WORDS]);
            end else begin
                rd_en = 1'b0;
            end
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            n_pass++;
            $display("%s: passed", test_name);
        end else begin
            n_fail++;
            $display("%s: failed with %0d errors", test_name, errors - err_mark);
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int frames;
        reset_n = 1'b0;
        rx = 1'b1;
        rd_en = 1'b0;
        rd_addr = '0;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;

        start_test("single_word");
        send_word(32'h1122_3344);  // Bytes go out as 11, 22, 33, 44.
        check_value(32'd1, 32'(word_count));
        read_burst(0, 1);
        end_test();

        start_test("interleave");
        repeat (RAND_WORDS) send_word($random(seed));
        check_value(exp_count, 32'(word_count));
        read_burst(0, exp_count);
        end_test();

        start_test("frame_error");
        frames = n_frame_err;
        send_byte(8'ha1, 1'b1);
        send_byte(8'hb2, 1'b1);
        send_bad_byte(8'hee);
        send_byte(8'hc3, 1'b1);
        send_byte(8'hd4, 1'b1);
        finish_word(32'ha1b2_c3d4);
        check_value(frames + 1, n_frame_err);
        check_value(exp_count, 32'(word_count));
        read_burst(exp_count - 1, 1);
        end_test();

        start_test("false_start");
        frames = n_frame_err;
        send_glitch();
        send_word($random(seed));
        check_value(frames, n_frame_err);
        check_value(exp_count, 32'(word_count));
        read_burst(exp_count - 1, 1);
        end_test();

        start_test("address_wrap");
        while (exp_count != 0) send_word($random(seed));
        check_value(32'd0, 32'(word_count));
        send_word($random(seed));  // Lands on address 0 again.
        check_value(32'd1, 32'(word_count));
        read_burst(0, 1);
        end_test();

        $display("Tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
        if (errors == 0 && n_fail == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/mem_pkg.sv
verilog/uart_rx.sv
verilog/word_assembler.sv
verilog/bank_ram.sv
verilog/bank_read_mux.sv
verilog/loader_top.sv
tb/loader_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module loader_tb -f compile.f -o loader_sim

./obj_dir/loader_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
